// ==== read_watchdog.f ====
+incdir+source
source/read_watchdog_pkg.sv
source/txn_table.sv
source/phase_timer.sv
source/guard_regs.sv
source/read_watchdog.sv
bench/tb_clock_gen.sv
bench/read_watchdog_tb.sv

// ==== Bender.yml ====
package:
  name: read_watchdog

sources:
  - include_dirs:
      - source
    files:
      - source/read_watchdog_pkg.sv
      - source/txn_table.sv
      - source/phase_timer.sv
      - source/guard_regs.sv
      - source/read_watchdog.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clock_gen.sv
      - bench/read_watchdog_tb.sv

// ==== bench/read_watchdog_tb.sv ====
/*
  Table-driven bench of the AXI read watchdog.
  The bench acts as both AXI master and slave and keeps reads in order.
  Latency checks allow one tick of prescaler phase.
*/
`timescale 1ns/1ps
`include "read_watchdog_cfg.svh"

module read_watchdog_tb;

  typedef enum int {
    reset_chk, normal, ar_stall, first_to, burst_to, unwanted_none, unwanted_id, recover
  } kind_e;

  typedef struct {
    kind_e       kind;
    int unsigned bud_ar;
    int unsigned bud_first;
    int unsigned bud_beat;
    int unsigned max_len;
    int unsigned d_first;
    int unsigned d_beat;
    logic [4:0]  exp_cause;
  } row_t;

  logic                        clk;
  logic                        rst_n;
  logic                        reset_clear;
  logic                        irq;
  logic                        reset_req;
  read_watchdog_pkg::ar_mon_t  ar;
  read_watchdog_pkg::r_mon_t   r;
  read_watchdog_pkg::reg_req_t reg_req;
  read_watchdog_pkg::reg_rsp_t reg_rsp;
  row_t                        rows [9];
  int unsigned                 cyc = 0;
  int                          errors;
  int                          rows_failed;

  tb_clock_gen clock_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  read_watchdog read_watchdog_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .ar_i          (ar),
    .r_i           (r),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .reset_clear_i (reset_clear),
    .irq_o         (irq),
    .reset_req_o   (reset_req)
  );

  // Edge counter that gives the number of the edge just taken when read right after it
  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_near(input string name, input int got, input int exp);
    assert ((got + 1 >= exp) && (got <= exp + 1)) else begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h within one tick", name, got, exp);
      errors++;
    end
  endtask

  task automatic reg_write(input logic [`RW_REG_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic read_check(input string name, input logic [`RW_REG_AW-1:0] addr,
                            input logic [31:0] exp);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
    @(posedge clk);
    reg_req <= '0;
    @(negedge clk);
    check_eq(name, reg_rsp.rdata, exp);
  endtask

  task automatic issue_ar(input logic [`RW_ID_W-1:0] id, input logic [`RW_ADDR_W-1:0] addr,
                          input logic [`RW_LEN_W-1:0] len);
    @(posedge clk);
    ar <= '{valid: 1'b1, ready: 1'b1, id: id, addr: addr, len: len};
    @(posedge clk);
    ar <= '0;
  endtask

  // Drives one accepted R beat and returns in t the edge it was driven on
  task automatic drive_beat(input logic [`RW_ID_W-1:0] id, input logic last, output int t);
    @(posedge clk);
    r <= '{valid: 1'b1, ready: 1'b1, id: id, last: last};
    t = cyc;
    @(posedge clk);
    r <= '0;
  endtask

  task automatic wait_irq(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!irq && n < limit);
    assert (irq) else begin
      $display("Timeout: irq_o stayed low for %0d cycles", limit);
      errors++;
    end
  endtask

  // Back-to-back ARs followed by in-order responses with latency checks
  task automatic run_reads(input int n, input int max_len, input int d_first, input int d_beat);
    logic [`RW_ID_W-1:0]  ids [4];
    logic [`RW_LEN_W-1:0] lens [4];
    int                   s;
    int                   b;
    int                   l;
    int                   t;
    int                   k;
    int                   j;
    for (k = 0; k < n; k++) begin
      ids[k]  = `RW_ID_W'($urandom());
      lens[k] = `RW_LEN_W'($urandom_range(max_len, 0));
      @(posedge clk);
      ar <= '{valid: 1'b1, ready: 1'b1, id: ids[k], addr: $urandom() & 32'hFFFF_FFFC,
              len: lens[k]};
      if (k == 0) s = cyc;
    end
    @(posedge clk);
    ar <= '0;
    for (k = 0; k < n; k++) begin
      repeat ($urandom_range(d_first, 1)) @(posedge clk);
      for (j = 0; j <= int'(lens[k]); j++) begin
        drive_beat(ids[k], j == int'(lens[k]), t);
        if (j == 0) b = t;
        l = t;
        if (j < int'(lens[k])) repeat ($urandom_range(d_beat, 0)) @(posedge clk);
      end
      @(posedge clk);
      reg_req <= '{valid: 1'b1, write: 1'b0, addr: `RW_REG_LAT_FIRST, wdata: 32'h0};
      @(posedge clk);
      reg_req <= '{valid: 1'b1, write: 1'b0, addr: `RW_REG_LAT_BURST, wdata: 32'h0};
      @(negedge clk);
      check_near("LAT_FIRST", reg_rsp.rdata, (b - s) / `RW_PRESCALE_DIV);
      @(posedge clk);
      reg_req <= '0;
      @(negedge clk);
      check_near("LAT_BURST", reg_rsp.rdata, (l - b) / `RW_PRESCALE_DIV);
      // Next head starts when this one pops
      s = l;
    end
  endtask

  // Drops the reset request and then clears all causes
  task automatic clear_fault();
    @(posedge clk);
    reset_clear <= 1'b1;
    @(posedge clk);
    reset_clear <= 1'b0;
    @(negedge clk);
    check_eq("reset_req_o", reset_req, 1'b0);
    check_eq("irq_o", irq, 1'b1);
    reg_write(`RW_REG_CAUSE, 32'hFFFF_FFFF);
    @(negedge clk);
    check_eq("irq_o", irq, 1'b0);
  endtask

  initial begin
    logic [`RW_ID_W-1:0]   id;
    logic [`RW_ADDR_W-1:0] addr;
    int                    t;
    int                    errs_before;
    ar          = '0;
    r           = '0;
    reg_req     = '0;
    reset_clear = 1'b0;
    errors      = 0;
    rows_failed = 0;
    void'($urandom(27448));

    // Kind, budgets ar/first/beat, max len field, first delay or wait limit,
    // beat gap or wait limit, expected CAUSE
    rows = '{
      '{reset_chk,     8, 16, 4, 0,  0,  0, 5'h00},
      '{normal,        8, 16, 4, 3,  6,  2, 5'h00},
      '{normal,        8, 16, 4, 3, 20,  6, 5'h00},
      '{ar_stall,      3, 16, 4, 0,  0,  0, 5'h01},
      '{first_to,      8,  2, 4, 0, 60,  0, 5'h02},
      '{burst_to,      8, 16, 1, 1,  4, 60, 5'h04},
      '{unwanted_none, 8, 16, 4, 0, 16,  0, 5'h08},
      '{unwanted_id,   8, 16, 4, 0, 16,  0, 5'h08},
      '{recover,       8, 16, 4, 2,  6,  2, 5'h08}
    };

    t = 0;
    while (!rst_n && t < 20) begin
      @(posedge clk);
      t++;
    end
    assert (rst_n) else begin
      $display("Reset was not released within 20 cycles");
      errors++;
    end
    @(negedge clk);

    foreach (rows[i]) begin
      errs_before = errors;
      id          = `RW_ID_W'($urandom());
      addr        = $urandom() & 32'hFFFF_FFF0;
      if (rows[i].kind != reset_chk) begin
        reg_write(`RW_REG_BUDGET_AR, rows[i].bud_ar);
        reg_write(`RW_REG_BUDGET_FIRST, rows[i].bud_first);
        reg_write(`RW_REG_BUDGET_BEAT, rows[i].bud_beat);
      end
      case (rows[i].kind)
        reset_chk: begin
          check_eq("irq_o", irq, 1'b0);
          check_eq("reset_req_o", reset_req, 1'b0);
          read_check("BUDGET_AR", `RW_REG_BUDGET_AR, `RW_DEF_BUDGET_AR);
          read_check("BUDGET_FIRST", `RW_REG_BUDGET_FIRST, `RW_DEF_BUDGET_FIRST);
          read_check("BUDGET_BEAT", `RW_REG_BUDGET_BEAT, `RW_DEF_BUDGET_BEAT);
        end
        normal: begin
          run_reads(4, rows[i].max_len, rows[i].d_first, rows[i].d_beat);
          read_check("CAUSE", `RW_REG_CAUSE, rows[i].exp_cause);
          check_eq("irq_o", irq, 1'b0);
        end
        ar_stall: begin
          @(posedge clk);
          ar <= '{valid: 1'b1, ready: 1'b0, id: id, addr: addr, len: '0};
          wait_irq(2 * (rows[i].bud_ar + 1) * `RW_PRESCALE_DIV);
          // The request stays stalled well past the whole window
          repeat (2 * (rows[i].bud_ar + 1) * `RW_PRESCALE_DIV) @(posedge clk);
          ar <= '0;
        end
        first_to: begin
          issue_ar(id, addr, rows[i].max_len);
          wait_irq(rows[i].d_first);
        end
        burst_to: begin
          issue_ar(id, addr, rows[i].max_len);
          repeat (rows[i].d_first) @(posedge clk);
          drive_beat(id, 1'b0, t);
          wait_irq(rows[i].d_beat);
        end
        unwanted_id: begin
          issue_ar(id, addr, '0);
          id   = id ^ `RW_ID_W'(1);
          addr = '0;
          drive_beat(id, 1'b1, t);
          wait_irq(rows[i].d_first);
        end
        default: begin
          // Beat with nothing outstanding
          addr = '0;
          drive_beat(id, 1'b1, t);
          wait_irq(rows[i].d_first);
        end
      endcase

      if (rows[i].exp_cause != '0) begin
        check_eq("irq_o", irq, 1'b1);
        check_eq("reset_req_o", reset_req, 1'b1);
        read_check("CAUSE", `RW_REG_CAUSE, rows[i].exp_cause);
        read_check("IRQ_ID", `RW_REG_IRQ_ID, id);
        read_check("IRQ_ADDR", `RW_REG_IRQ_ADDR, addr);
        clear_fault();
      end
      if (rows[i].kind == recover) begin
        run_reads(1, rows[i].max_len, rows[i].d_first, rows[i].d_beat);
        read_check("CAUSE", `RW_REG_CAUSE, 32'h0);
        check_eq("irq_o", irq, 1'b0);
      end

      if (errors == errs_before) begin
        $display("Row %0d %s: ok", i, rows[i].kind.name());
      end else begin
        rows_failed++;
        $display("Row %0d %s: failed", i, rows[i].kind.name());
      end
    end

    $display("Rows run: %0d, rows failed: %0d, errors: %0d", $size(rows), rows_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
  Clock and reset source for the watchdog bench.
  10 ns period, reset held low for the first 4 rising edges.
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== source/read_watchdog.sv ====
/*
  AXI read-channel watchdog, passive on AR and R.
  Reads must complete in order. Up to RW_MAX_TXNS reads are tracked.
*/
`timescale 1ns/1ps

module read_watchdog (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  read_watchdog_pkg::ar_mon_t  ar_i,
  input  read_watchdog_pkg::r_mon_t   r_i,
  input  read_watchdog_pkg::reg_req_t reg_req_i,
  output read_watchdog_pkg::reg_rsp_t reg_rsp_o,
  input  logic                        reset_clear_i,
  output logic                        irq_o,
  output logic                        reset_req_o
);

  read_watchdog_pkg::txn_t     push_txn;
  read_watchdog_pkg::head_t    head;
  read_watchdog_pkg::budget_t  budget;
  read_watchdog_pkg::fault_t   fault;
  read_watchdog_pkg::latency_t latency;

  logic push;
  logic pop;
  logic overflow;

  // Every AR handshake enters the table
  assign push          = ar_i.valid && ar_i.ready;
  assign push_txn.id   = ar_i.id;
  assign push_txn.addr = ar_i.addr;
  assign push_txn.len  = ar_i.len;

  txn_table txn_table_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (push),
    .push_txn_i (push_txn),
    .pop_i      (pop),
    .flush_i    (fault.valid),
    .head_o     (head),
    .overflow_o (overflow)
  );

  phase_timer phase_timer_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ar_i       (ar_i),
    .r_i        (r_i),
    .head_i     (head),
    .overflow_i (overflow),
    .budget_i   (budget),
    .pop_o      (pop),
    .fault_o    (fault),
    .latency_o  (latency)
  );

  guard_regs guard_regs_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .fault_i       (fault),
    .latency_i     (latency),
    .reset_clear_i (reset_clear_i),
    .budget_o      (budget),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o)
  );

endmodule

// ==== source/guard_regs.sv ====
/*
  Register block of the read watchdog.
  CAUSE is write-one-to-clear, other captured fields are read-only.
  Read data is registered and follows a read request by one cycle.
*/
`timescale 1ns/1ps
`include "read_watchdog_cfg.svh"

module guard_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  read_watchdog_pkg::reg_req_t reg_req_i,
  output read_watchdog_pkg::reg_rsp_t reg_rsp_o,
  input  read_watchdog_pkg::fault_t   fault_i,
  input  read_watchdog_pkg::latency_t latency_i,
  input  logic                        reset_clear_i,
  output read_watchdog_pkg::budget_t  budget_o,
  output logic                        irq_o,
  output logic                        reset_req_o
);

  read_watchdog_pkg::budget_t budget_q;
  read_watchdog_pkg::cause_t  cause_q;
  read_watchdog_pkg::cause_t  cause_w1c;

  logic [`RW_ADDR_W-1:0] irq_addr_q;
  logic [`RW_ID_W-1:0]   irq_id_q;
  logic [`RW_CNT_W-1:0]  lat_first_q;
  logic [`RW_CNT_W-1:0]  lat_burst_q;
  logic                  reset_req_q;
  logic                  wr_en;
  logic                  rd_en;
  logic [31:0]           rdata_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign rd_en = reg_req_i.valid && !reg_req_i.write;

  // Bits written as one on CAUSE are cleared
  assign cause_w1c = (wr_en && (reg_req_i.addr == `RW_REG_CAUSE)) ?
                     read_watchdog_pkg::cause_t'(reg_req_i.wdata[4:0]) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budget_q.ar    <= `RW_CNT_W'(`RW_DEF_BUDGET_AR);
      budget_q.first <= `RW_CNT_W'(`RW_DEF_BUDGET_FIRST);
      budget_q.beat  <= `RW_CNT_W'(`RW_DEF_BUDGET_BEAT);
    end else if (wr_en) begin
      case (reg_req_i.addr)
        `RW_REG_BUDGET_AR:    budget_q.ar    <= reg_req_i.wdata[`RW_CNT_W-1:0];
        `RW_REG_BUDGET_FIRST: budget_q.first <= reg_req_i.wdata[`RW_CNT_W-1:0];
        `RW_REG_BUDGET_BEAT:  budget_q.beat  <= reg_req_i.wdata[`RW_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  // Fault capture, a new fault wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cause_q     <= '0;
      irq_addr_q  <= '0;
      irq_id_q    <= '0;
      reset_req_q <= 1'b0;
    end else begin
      cause_q <= (cause_q & ~cause_w1c) | (fault_i.valid ? fault_i.cause : '0);
      if (fault_i.valid) begin
        irq_addr_q  <= fault_i.addr;
        irq_id_q    <= fault_i.id;
        reset_req_q <= 1'b1;
      end else if (reset_clear_i) begin
        reset_req_q <= 1'b0;
      end
    end
  end

  // Last completed read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_first_q <= '0;
      lat_burst_q <= '0;
    end else if (latency_i.valid) begin
      lat_first_q <= latency_i.first;
      lat_burst_q <= latency_i.burst;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      case (reg_req_i.addr)
        `RW_REG_BUDGET_AR:    rdata_q <= 32'(budget_q.ar);
        `RW_REG_BUDGET_FIRST: rdata_q <= 32'(budget_q.first);
        `RW_REG_BUDGET_BEAT:  rdata_q <= 32'(budget_q.beat);
        `RW_REG_CAUSE:        rdata_q <= 32'(cause_q);
        `RW_REG_IRQ_ADDR:     rdata_q <= 32'(irq_addr_q);
        `RW_REG_IRQ_ID:       rdata_q <= 32'(irq_id_q);
        `RW_REG_LAT_FIRST:    rdata_q <= 32'(lat_first_q);
        `RW_REG_LAT_BURST:    rdata_q <= 32'(lat_burst_q);
        default:              rdata_q <= '0;
      endcase
    end
  end

  assign reg_rsp_o.rdata = rdata_q;
  assign budget_o        = budget_q;
  assign irq_o           = |cause_q;
  assign reset_req_o     = reset_req_q;

  // A reset request always comes with a pending cause
  a_irq_with_reset_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(reset_req_o) |-> irq_o
  ) else $error("reset_req_o rose without irq_o");

endmodule

// ==== source/phase_timer.sv ====
/*
  Phase timing of the AR stall and of the oldest outstanding read.
  Counters advance once per prescaled tick and saturate at all ones.
  Responses are assumed in order, so only the table head is timed.
*/
`timescale 1ns/1ps
`include "read_watchdog_cfg.svh"

module phase_timer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  read_watchdog_pkg::ar_mon_t  ar_i,
  input  read_watchdog_pkg::r_mon_t   r_i,
  input  read_watchdog_pkg::head_t    head_i,
  input  logic                        overflow_i,
  input  read_watchdog_pkg::budget_t  budget_i,
  output logic                        pop_o,
  output read_watchdog_pkg::fault_t   fault_o,
  output read_watchdog_pkg::latency_t latency_o
);

  localparam int unsigned PreW = (`RW_PRESCALE_DIV > 1) ? $clog2(`RW_PRESCALE_DIV) : 1;
  localparam int unsigned BudW = `RW_CNT_W + `RW_LEN_W + 1;

  logic [PreW-1:0]      presc_q;
  logic                 tick;
  logic                 ar_stalling;
  logic                 ar_reported_q;
  logic [`RW_CNT_W-1:0] ar_cnt_q;
  logic                 in_data_q;
  logic [`RW_CNT_W-1:0] first_cnt_q;
  logic [`RW_CNT_W-1:0] burst_cnt_q;
  logic                 beat_acc;
  logic                 id_match;
  logic                 head_beat;
  logic                 head_done;
  logic [BudW-1:0]      burst_budget;

  read_watchdog_pkg::cause_t cause;

  // Prescaler
  assign tick = (presc_q == PreW'(`RW_PRESCALE_DIV - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_q <= '0;
    end else if (tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + PreW'(1);
    end
  end

  assign ar_stalling = ar_i.valid && !ar_i.ready;

  assign beat_acc  = r_i.valid && r_i.ready;
  assign id_match  = head_i.valid && (r_i.id == head_i.txn.id);
  assign head_beat = beat_acc && id_match;
  assign head_done = head_beat && r_i.last;

  // Burst allowance scales with the beat count
  assign burst_budget = BudW'(budget_i.beat) * (BudW'(head_i.txn.len) + BudW'(1));

  always_comb begin
    cause               = '0;
    cause.ar_stall      = ar_stalling && !ar_reported_q && (ar_cnt_q > budget_i.ar);
    cause.first_timeout = head_i.valid && !in_data_q && (first_cnt_q > budget_i.first);
    cause.burst_timeout = head_i.valid && in_data_q && (BudW'(burst_cnt_q) > burst_budget);
    cause.unwanted      = beat_acc && !id_match;
    cause.overflow      = overflow_i;
  end

  // Table causes take precedence for the captured fields
  always_comb begin
    fault_o       = '0;
    fault_o.valid = |cause;
    fault_o.cause = cause;
    if (cause.first_timeout || cause.burst_timeout || cause.overflow) begin
      fault_o.addr = head_i.txn.addr;
      fault_o.id   = head_i.txn.id;
    end else if (cause.ar_stall) begin
      fault_o.addr = ar_i.addr;
      fault_o.id   = ar_i.id;
    end else if (cause.unwanted) begin
      fault_o.id = r_i.id;
    end
  end

  // A fault flushes the table, so the head is not popped as well
  assign pop_o = head_done && !fault_o.valid;

  assign latency_o.valid = pop_o;
  assign latency_o.first = first_cnt_q;
  assign latency_o.burst = burst_cnt_q;

  // AR stall counter that reports once per stalled request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_cnt_q      <= '0;
      ar_reported_q <= 1'b0;
    end else if (!ar_stalling) begin
      ar_cnt_q      <= '0;
      ar_reported_q <= 1'b0;
    end else begin
      if (tick && (ar_cnt_q != '1)) begin
        ar_cnt_q <= ar_cnt_q + `RW_CNT_W'(1);
      end
      if (cause.ar_stall) begin
        ar_reported_q <= 1'b1;
      end
    end
  end

  // Head phase and its two counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_data_q   <= 1'b0;
      first_cnt_q <= '0;
      burst_cnt_q <= '0;
    end else if (pop_o || fault_o.valid) begin
      in_data_q   <= 1'b0;
      first_cnt_q <= '0;
      burst_cnt_q <= '0;
    end else if (head_i.valid) begin
      if (head_beat) begin
        in_data_q <= 1'b1;
      end
      if (tick && !in_data_q && (first_cnt_q != '1)) begin
        first_cnt_q <= first_cnt_q + `RW_CNT_W'(1);
      end
      if (tick && in_data_q && (burst_cnt_q != '1)) begin
        burst_cnt_q <= burst_cnt_q + `RW_CNT_W'(1);
      end
    end
  end

  // The timed head only moves on a pop or a flush
  a_head_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    head_i.valid && !pop_o && !fault_o.valid |=> head_i.valid && $stable(head_i.txn)
  ) else $error("phase_timer head changed without pop or flush");

endmodule

// ==== source/txn_table.sv ====
/*
  In-order table of accepted reads, oldest entry on head_o.
  A push while full is dropped and flagged on overflow_o.
  Flush wins over push and pop in the same cycle.
*/
`timescale 1ns/1ps
`include "read_watchdog_cfg.svh"

module txn_table (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  read_watchdog_pkg::txn_t  push_txn_i,
  input  logic                     pop_i,
  input  logic                     flush_i,
  output read_watchdog_pkg::head_t head_o,
  output logic                     overflow_o
);

  localparam int unsigned PtrW = (`RW_MAX_TXNS > 1) ? $clog2(`RW_MAX_TXNS) : 1;
  localparam int unsigned CntW = $clog2(`RW_MAX_TXNS + 1);

  read_watchdog_pkg::txn_t mem_q [`RW_MAX_TXNS];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full;
  logic            empty;
  logic            do_push;
  logic            do_pop;

  assign full  = (count_q == CntW'(`RW_MAX_TXNS));
  assign empty = (count_q == '0);

  assign do_push = push_i && !full && !flush_i;
  assign do_pop  = pop_i && !empty && !flush_i;

  // A request that finds no free slot is lost
  assign overflow_o = push_i && full && !flush_i;

  assign head_o.valid = !empty;
  assign head_o.txn   = mem_q[rd_ptr_q];

  // Entry storage, written only on an accepted push
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_txn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == PtrW'(`RW_MAX_TXNS - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + PtrW'(1);
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == PtrW'(`RW_MAX_TXNS - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + PtrW'(1);
        end
      end
      // Count moves only when exactly one side acts
      if (do_push && !do_pop) begin
        count_q <= count_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  // The timer pops only a head it has seen valid
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty
  ) else $error("txn_table popped while empty");

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntW'(`RW_MAX_TXNS)
  ) else $error("txn_table count above capacity");

endmodule

// ==== source/read_watchdog_pkg.sv ====
/*
  Shared struct types of the read watchdog.
  All widths come from the cfg header.
*/
`include "read_watchdog_cfg.svh"

package read_watchdog_pkg;

  // AR channel as seen by the monitor
  typedef struct packed {
    logic                  valid;
    logic                  ready;
    logic [`RW_ID_W-1:0]   id;
    logic [`RW_ADDR_W-1:0] addr;
    logic [`RW_LEN_W-1:0]  len;
  } ar_mon_t;

  typedef struct packed {
    logic                valid;
    logic                ready;
    logic [`RW_ID_W-1:0] id;
    logic                last;
  } r_mon_t;

  // One tracked read
  typedef struct packed {
    logic [`RW_ID_W-1:0]   id;
    logic [`RW_ADDR_W-1:0] addr;
    logic [`RW_LEN_W-1:0]  len;
  } txn_t;

  typedef struct packed {
    logic valid;
    txn_t txn;
  } head_t;

  typedef struct packed {
    logic [`RW_CNT_W-1:0] ar;
    logic [`RW_CNT_W-1:0] first;
    logic [`RW_CNT_W-1:0] beat;
  } budget_t;

  // Last field is bit 0
  typedef struct packed {
    logic overflow;
    logic unwanted;
    logic burst_timeout;
    logic first_timeout;
    logic ar_stall;
  } cause_t;

  typedef struct packed {
    logic                  valid;
    cause_t                cause;
    logic [`RW_ADDR_W-1:0] addr;
    logic [`RW_ID_W-1:0]   id;
  } fault_t;

  typedef struct packed {
    logic                 valid;
    logic [`RW_CNT_W-1:0] first;
    logic [`RW_CNT_W-1:0] burst;
  } latency_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [`RW_REG_AW-1:0] addr;
    logic [31:0]           wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

// ==== source/read_watchdog_cfg.svh ====
/*
  Sizes, register map and reset budgets for the AXI read watchdog.
  Budgets count prescaled ticks. RW_PRESCALE_DIV must be 2 or more.
  Register offsets assume a byte-addressed bus with word-aligned access.
*/
`ifndef READ_WATCHDOG_CFG_SVH
`define READ_WATCHDOG_CFG_SVH

// Table and bus sizes
`define RW_MAX_TXNS 4
`define RW_ID_W 4
`define RW_ADDR_W 32
`define RW_LEN_W 8
`define RW_CNT_W 12
`define RW_PRESCALE_DIV 4
`define RW_REG_AW 5

// Register offsets
`define RW_REG_BUDGET_AR 5'h00
`define RW_REG_BUDGET_FIRST 5'h04
`define RW_REG_BUDGET_BEAT 5'h08
`define RW_REG_CAUSE 5'h0C
`define RW_REG_IRQ_ADDR 5'h10
`define RW_REG_IRQ_ID 5'h14
`define RW_REG_LAT_FIRST 5'h18
`define RW_REG_LAT_BURST 5'h1C

// Budgets after reset, in ticks
`define RW_DEF_BUDGET_AR 8
`define RW_DEF_BUDGET_FIRST 16
`define RW_DEF_BUDGET_BEAT 4

`endif
